//--- design/mem_stage_pkg.sv
package mem_stage_pkg;

  // ======================================================================
  // Data path widths
  // ======================================================================

  // Data or address word
  typedef logic [31:0] word_t;
  // One write strobe per byte lane
  typedef logic [3:0] strb_t;
  // Destination register index
  typedef logic [4:0] reg_idx_t;
  // Load/store width code from the instruction
  typedef logic [2:0] funct3_t;
  // Which unit supplies the stage result
  typedef logic [2:0] res_src_t;
  // Trap cause carried to WB
  typedef logic [1:0] trap_code_t;

  // ======================================================================
  // Named codes
  // ======================================================================

  // RISC-V funct3 encodings for loads and stores
  localparam funct3_t F3_B  = 3'd0;
  localparam funct3_t F3_H  = 3'd1;
  localparam funct3_t F3_W  = 3'd2;
  localparam funct3_t F3_BU = 3'd4;
  localparam funct3_t F3_HU = 3'd5;

  // Access size, taken from funct3[1:0]
  localparam logic [1:0] SZ_B = 2'd0;
  localparam logic [1:0] SZ_H = 2'd1;
  localparam logic [1:0] SZ_W = 2'd2;

  // Result source select
  localparam res_src_t RES_ALU = 3'd0;
  localparam res_src_t RES_MEM = 3'd1;
  localparam res_src_t RES_PC4 = 3'd2;
  localparam res_src_t RES_TGT = 3'd3;
  localparam res_src_t RES_M   = 3'd4;

  // Load/store address misaligned
  localparam trap_code_t TRAP_LDST_MISALIGN = 2'd2;

endpackage

//--- design/store_formatter.sv
module store_formatter
  import mem_stage_pkg::*;
(
  input  funct3_t    funct3_i,
  input  logic [1:0] addr_lo_i,
  input  word_t      data_i,
  output word_t      wdata_o,
  output strb_t      wstrb_o
);

  // Access size from the low funct3 bits
  logic [1:0] size;

  assign size = funct3_i[1:0];

  // ======================================================================
  // Lane replication
  // ======================================================================

  // Replicate the store value so every lane carries it
  // The strobes then pick which lanes are written
  always_comb begin
    case (size)
      SZ_B: wdata_o = {4{data_i[7:0]}};
      SZ_H: wdata_o = {2{data_i[15:0]}};
      default: wdata_o = data_i;
    endcase
  end

  // ======================================================================
  // Byte strobes
  // ======================================================================

  always_comb begin
    case (size)
      // One lane at the byte offset
      SZ_B: wstrb_o = 4'b0001 << addr_lo_i;
      // Lower or upper halfword, bit 0 is ignored here
      SZ_H: begin
        if (addr_lo_i[1]) begin
          wstrb_o = 4'b1100;
        end else begin
          wstrb_o = 4'b0011;
        end
      end
      // Full word
      default: wstrb_o = 4'b1111;
    endcase
  end

endmodule

//--- design/load_formatter.sv
module load_formatter
  import mem_stage_pkg::*;
(
  input  funct3_t    funct3_i,
  input  logic [1:0] addr_lo_i,
  input  word_t      rdata_i,
  output word_t      data_o
);

  // Addressed byte and halfword of the read word
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // ======================================================================
  // Lane selection
  // ======================================================================

  // Bring the addressed byte down to bit 0
  always_comb begin
    case (addr_lo_i)
      2'd0: ld_byte = rdata_i[7:0];
      2'd1: ld_byte = rdata_i[15:8];
      2'd2: ld_byte = rdata_i[23:16];
      default: ld_byte = rdata_i[31:24];
    endcase
  end

  // Halfword select uses bit 1 only
  // A misaligned halfword traps upstream, so bit 0 does not matter
  assign ld_half = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ======================================================================
  // Extension
  // ======================================================================

  always_comb begin
    case (funct3_i)
      // Signed byte and halfword
      F3_B: data_o = {{24{ld_byte[7]}}, ld_byte};
      F3_H: data_o = {{16{ld_half[15]}}, ld_half};
      // Unsigned byte and halfword
      F3_BU: data_o = {24'd0, ld_byte};
      F3_HU: data_o = {16'd0, ld_half};
      // Word is passed as read
      F3_W: data_o = rdata_i;
      // Unused codes, keep the raw word
      default: data_o = rdata_i;
    endcase
  end

endmodule

//--- design/mem_access_unit.sv
module mem_access_unit
  import mem_stage_pkg::*;
(
  input  logic       s_valid_i,
  input  logic       mem_read_i,
  input  logic       mem_write_i,
  input  logic       trap_i,
  input  funct3_t    funct3_i,
  input  word_t      addr_i,
  input  word_t      store_data_i,
  input  trap_code_t trap_code_i,
  output logic       dmem_ren_o,
  output logic       dmem_we_o,
  output word_t      dmem_addr_o,
  output word_t      dmem_wdata_o,
  output strb_t      dmem_wstrb_o,
  output logic       trap_o,
  output trap_code_t trap_code_o
);

  // Formatter strobes before gating
  strb_t st_wstrb;
  // Misaligned halfword or word access
  logic  misalign;

  store_formatter u_store_formatter (
    .funct3_i  (funct3_i),
    .addr_lo_i (addr_i[1:0]),
    .data_i    (store_data_i),
    .wdata_o   (dmem_wdata_o),
    .wstrb_o   (st_wstrb)
  );

  // ======================================================================
  // Misalignment check
  // ======================================================================

  // Only an actual load or store can be misaligned
  always_comb begin
    misalign = 1'b0;
    if (mem_read_i || mem_write_i) begin
      case (funct3_i[1:0])
        SZ_H: misalign = addr_i[0];
        SZ_W: misalign = |addr_i[1:0];
        default: misalign = 1'b0;
      endcase
    end
  end

  // Misalignment overrides the incoming cause
  assign trap_o      = trap_i | misalign;
  assign trap_code_o = misalign ? TRAP_LDST_MISALIGN : trap_code_i;

  // ======================================================================
  // Memory request
  // ======================================================================

  // No memory side effect for a trapping or invalid instruction
  assign dmem_ren_o   = s_valid_i && mem_read_i && !trap_o;
  assign dmem_we_o    = s_valid_i && mem_write_i && !trap_o;
  assign dmem_addr_o  = {addr_i[31:2], 2'b00};
  assign dmem_wstrb_o = mem_write_i ? st_wstrb : 4'b0000;

endmodule

//--- design/mem_wb_reg.sv
module mem_wb_reg
  import mem_stage_pkg::*;
#(
  parameter int PIPELINED = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       s_valid_i,
  input  logic       stall_i,
  input  logic       reg_write_i,
  input  logic       trap_i,
  input  trap_code_t trap_code_i,
  input  reg_idx_t   rd_i,
  input  res_src_t   res_src_i,
  input  word_t      result_i,
  input  word_t      ld_data_i,
  output logic       m_valid_o,
  output logic       reg_write_o,
  output logic       trap_o,
  output trap_code_t trap_code_o,
  output reg_idx_t   rd_o,
  output res_src_t   res_src_o,
  output word_t      result_o,
  output word_t      ld_data_o
);

  if (PIPELINED != 0) begin : g_reg

    // ====================================================================
    // Control bits
    // ====================================================================

    // These trigger register writes and traps in WB
    // A bubble clears them so WB never has to look at valid again
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        m_valid_o   <= 1'b0;
        reg_write_o <= 1'b0;
        trap_o      <= 1'b0;
      end else if (!stall_i) begin
        m_valid_o   <= s_valid_i;
        reg_write_o <= s_valid_i && reg_write_i;
        trap_o      <= s_valid_i && trap_i;
      end
    end

    // ====================================================================
    // Payload
    // ====================================================================

    // Loaded on every advance, may be stale behind a bubble
    always_ff @(posedge clk) begin
      if (!stall_i) begin
        trap_code_o <= trap_code_i;
        rd_o        <= rd_i;
        res_src_o   <= res_src_i;
        result_o    <= result_i;
        ld_data_o   <= ld_data_i;
      end
    end

  end else begin : g_pass

    // Single-cycle build, WB sees the MEM values directly
    // Control still masked by valid
    assign m_valid_o   = s_valid_i;
    assign reg_write_o = s_valid_i && reg_write_i;
    assign trap_o      = s_valid_i && trap_i;
    assign trap_code_o = trap_code_i;
    assign rd_o        = rd_i;
    assign res_src_o   = res_src_i;
    assign result_o    = result_i;
    assign ld_data_o   = ld_data_i;

  end

endmodule

//--- design/mem_stage.sv
module mem_stage
  import mem_stage_pkg::*;
#(
  parameter int PIPELINED = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  // EX side
  input  logic       s_valid_i,
  input  logic       stall_i,
  input  logic       reg_write_i,
  input  logic       mem_read_i,
  input  logic       mem_write_i,
  input  res_src_t   res_src_i,
  input  logic       trap_i,
  input  trap_code_t trap_code_i,
  input  reg_idx_t   rd_i,
  input  funct3_t    funct3_i,
  input  word_t      alu_result_i,
  input  word_t      rs2_data_i,
  input  word_t      pc_plus4_i,
  input  word_t      jb_tgt_i,
  input  word_t      m_result_i,
  // Data memory
  output logic       dmem_ren_o,
  output word_t      dmem_raddr_o,
  input  word_t      dmem_rdata_i,
  output logic       dmem_we_o,
  output word_t      dmem_waddr_o,
  output word_t      dmem_wdata_o,
  output strb_t      dmem_wstrb_o,
  // Forwarding
  output word_t      result_mem_o,
  output word_t      ld_data_mem_o,
  // WB side
  output logic       m_valid_o,
  output logic       reg_write_o,
  output logic       trap_o,
  output trap_code_t trap_code_o,
  output reg_idx_t   rd_o,
  output res_src_t   res_src_o,
  output word_t      result_wb_o,
  output word_t      ld_data_wb_o
);

  // Merged trap and cause from the access unit
  logic       mem_trap;
  trap_code_t mem_trap_code;
  // Shared word address for read and write
  word_t      dmem_addr;
  // Register write killed by a trap
  logic       reg_write_gated;

  // ======================================================================
  // Memory access and load formatting
  // ======================================================================

  mem_access_unit u_mem_access_unit (
    .s_valid_i    (s_valid_i),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .trap_i       (trap_i),
    .funct3_i     (funct3_i),
    .addr_i       (alu_result_i),
    .store_data_i (rs2_data_i),
    .trap_code_i  (trap_code_i),
    .dmem_ren_o   (dmem_ren_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_wstrb_o (dmem_wstrb_o),
    .trap_o       (mem_trap),
    .trap_code_o  (mem_trap_code)
  );

  assign dmem_raddr_o = dmem_addr;
  assign dmem_waddr_o = dmem_addr;

  // Memory reads in the same cycle, so the load is formatted here
  load_formatter u_load_formatter (
    .funct3_i  (funct3_i),
    .addr_lo_i (alu_result_i[1:0]),
    .rdata_i   (dmem_rdata_i),
    .data_o    (ld_data_mem_o)
  );

  // ======================================================================
  // Forwarded stage result
  // ======================================================================

  always_comb begin
    case (res_src_i)
      RES_M: result_mem_o = m_result_i;
      RES_PC4: result_mem_o = pc_plus4_i;
      RES_TGT: result_mem_o = jb_tgt_i;
      // Load data forwards on its own port, the address goes here
      RES_ALU, RES_MEM: result_mem_o = alu_result_i;
      default: result_mem_o = alu_result_i;
    endcase
  end

  // ======================================================================
  // MEM/WB register
  // ======================================================================

  assign reg_write_gated = reg_write_i && !mem_trap;

  mem_wb_reg #(
    .PIPELINED (PIPELINED)
  ) u_mem_wb_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_valid_i   (s_valid_i),
    .stall_i     (stall_i),
    .reg_write_i (reg_write_gated),
    .trap_i      (mem_trap),
    .trap_code_i (mem_trap_code),
    .rd_i        (rd_i),
    .res_src_i   (res_src_i),
    .result_i    (result_mem_o),
    .ld_data_i   (ld_data_mem_o),
    .m_valid_o   (m_valid_o),
    .reg_write_o (reg_write_o),
    .trap_o      (trap_o),
    .trap_code_o (trap_code_o),
    .rd_o        (rd_o),
    .res_src_o   (res_src_o),
    .result_o    (result_wb_o),
    .ld_data_o   (ld_data_wb_o)
  );

endmodule

//--- testbench/mem_stage_checker.sv
module mem_stage_checker
  import mem_stage_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Stimulus as the DUT sees it
  input  logic       s_valid_i, stall_i, reg_write_i, mem_read_i, mem_write_i, trap_i,
  input  res_src_t   res_src_i,
  input  trap_code_t trap_code_i,
  input  reg_idx_t   rd_i,
  input  funct3_t    funct3_i,
  input  word_t      alu_result_i, rs2_data_i, pc_plus4_i, jb_tgt_i, m_result_i,
  // DUT responses
  input  logic       dmem_ren_i, dmem_we_i,
  input  word_t      dmem_raddr_i, dmem_waddr_i, dmem_wdata_i,
  input  strb_t      dmem_wstrb_i,
  input  word_t      result_mem_i, ld_data_mem_i,
  input  logic       wb_valid_i, wb_reg_write_i, wb_trap_i,
  input  trap_code_t wb_trap_code_i,
  input  reg_idx_t   wb_rd_i,
  input  res_src_t   wb_res_src_i,
  input  word_t      result_wb_i, ld_data_wb_i,
  output int         check_count_o,
  output int         error_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int         checks = 0;
  int         errors = 0;
  // Shadow of the data memory
  word_t      shadow [16];
  // Set once reset has been seen
  logic       exp_known = 1'b0;
  // Expected MEM/WB contents
  logic       exp_valid, exp_reg_write, exp_trap, exp_ld_ok;
  trap_code_t exp_code;
  reg_idx_t   exp_rd;
  res_src_t   exp_src;
  word_t      exp_result, exp_ld;

  assign check_count_o = checks;
  assign error_count_o = errors;

  // Same starting contents as the memory model
  function automatic word_t fill_word(input int idx);
    return word_t'(idx) * 32'h2545_F491 ^ 32'h8F1B_6C3D;
  endfunction

  initial begin
    for (int i = 0; i < 16; i++) begin
      shadow[i] = fill_word(i);
    end
  end

  // ======================================================================
  // Reference model
  // ======================================================================

  // Bytes moved by the access
  function automatic logic [2:0] access_bytes(input funct3_t f3);
    case (f3[1:0])
      2'd0: return 3'd1;
      2'd1: return 3'd2;
      default: return 3'd4;
    endcase
  endfunction

  // Offset must be a multiple of the access size
  function automatic logic is_misaligned(input funct3_t f3, input word_t addr,
                                         input logic rd, input logic wr);
    logic [2:0] nb;
    nb = access_bytes(f3);
    return (rd || wr) && ((addr[1:0] & (nb[1:0] - 2'd1)) != 2'd0);
  endfunction

  function automatic strb_t write_strobes(input funct3_t f3, input logic [1:0] off);
    logic [4:0] ones;
    ones = (5'd1 << access_bytes(f3)) - 5'd1;
    return ones[3:0] << off;
  endfunction

  function automatic word_t replicate_lanes(input funct3_t f3, input word_t d);
    case (access_bytes(f3))
      3'd1: return {4{d[7:0]}};
      3'd2: return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  function automatic word_t extend_load(input funct3_t f3, input logic [1:0] off,
                                        input word_t w);
    word_t sh;
    sh = w >> {off, 3'b000};
    case (f3)
      F3_B: return {{24{sh[7]}}, sh[7:0]};
      F3_BU: return {24'd0, sh[7:0]};
      F3_H: return {{16{sh[15]}}, sh[15:0]};
      F3_HU: return {16'd0, sh[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic word_t pick_result(input res_src_t src, input word_t alu, input word_t pc4,
                                        input word_t tgt, input word_t m);
    case (src)
      RES_PC4: return pc4;
      RES_TGT: return tgt;
      RES_M: return m;
      default: return alu;
    endcase
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ======================================================================
  // Comparison at mid-cycle while everything is stable
  // ======================================================================

  always @(negedge clk) begin
    logic  mis;
    logic  trap_now;
    logic  we_exp;
    word_t ld_exp;
    word_t res_exp;
    word_t wdata_exp;
    strb_t strb_exp;
    // WB outputs after the last edge
    if (exp_known) begin
      check_value("m_valid_o", 32'(wb_valid_i), 32'(exp_valid));
      check_value("reg_write_o", 32'(wb_reg_write_i), 32'(exp_reg_write));
      check_value("trap_o", 32'(wb_trap_i), 32'(exp_trap));
      if (exp_valid) begin
        check_value("rd_o", 32'(wb_rd_i), 32'(exp_rd));
        check_value("res_src_o", 32'(wb_res_src_i), 32'(exp_src));
        check_value("trap_code_o", 32'(wb_trap_code_i), 32'(exp_code));
        check_value("result_wb_o", result_wb_i, exp_result);
        if (exp_ld_ok) begin
          check_value("ld_data_wb_o", ld_data_wb_i, exp_ld);
        end
      end
    end
    // Combinational outputs for the current inputs
    mis       = is_misaligned(funct3_i, alu_result_i, mem_read_i, mem_write_i);
    trap_now  = trap_i || mis;
    we_exp    = s_valid_i && mem_write_i && !trap_now;
    strb_exp  = write_strobes(funct3_i, alu_result_i[1:0]);
    wdata_exp = replicate_lanes(funct3_i, rs2_data_i);
    ld_exp    = extend_load(funct3_i, alu_result_i[1:0], shadow[alu_result_i[5:2]]);
    res_exp   = pick_result(res_src_i, alu_result_i, pc_plus4_i, jb_tgt_i, m_result_i);
    check_value("dmem_ren_o", 32'(dmem_ren_i), 32'(s_valid_i && mem_read_i && !trap_now));
    check_value("dmem_we_o", 32'(dmem_we_i), 32'(we_exp));
    check_value("dmem_raddr_o", dmem_raddr_i, {alu_result_i[31:2], 2'b00});
    check_value("dmem_waddr_o", dmem_waddr_i, {alu_result_i[31:2], 2'b00});
    check_value("result_mem_o", result_mem_i, res_exp);
    if (!mem_write_i) begin
      check_value("dmem_wstrb_o", 32'(dmem_wstrb_i), 32'd0);
    end else if (!mis) begin
      check_value("dmem_wstrb_o", 32'(dmem_wstrb_i), 32'(strb_exp));
      check_value("dmem_wdata_o", dmem_wdata_i, wdata_exp);
    end
    if (mem_read_i && !mis) begin
      check_value("ld_data_mem_o", ld_data_mem_i, ld_exp);
    end
    // Shadow takes the store at the coming edge
    if (we_exp) begin
      for (int b = 0; b < 4; b++) begin
        if (strb_exp[b]) begin
          shadow[alu_result_i[5:2]][8*b +: 8] = wdata_exp[8*b +: 8];
        end
      end
    end
    // Expected MEM/WB register after the coming edge
    if (!rst_n) begin
      exp_known     = 1'b1;
      exp_valid     = 1'b0;
      exp_reg_write = 1'b0;
      exp_trap      = 1'b0;
    end else if (!stall_i) begin
      exp_valid     = s_valid_i;
      exp_reg_write = s_valid_i && reg_write_i && !trap_now;
      exp_trap      = s_valid_i && trap_now;
      exp_code      = mis ? TRAP_LDST_MISALIGN : trap_code_i;
      exp_rd        = rd_i;
      exp_src       = res_src_i;
      exp_result    = res_exp;
      exp_ld        = ld_exp;
      exp_ld_ok     = mem_read_i && !mis;
    end
  end

endmodule

//--- testbench/tb_mem_stage.sv
module tb_mem_stage
  import mem_stage_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Operations in the random sequence
  localparam int N_OPS = 600;

  logic       clk = 1'b0;
  logic       rst_n;
  // EX side stimulus
  logic       s_valid_i, stall_i, reg_write_i, mem_read_i, mem_write_i, trap_i;
  res_src_t   res_src_i;
  trap_code_t trap_code_i;
  reg_idx_t   rd_i;
  funct3_t    funct3_i;
  word_t      alu_result_i, rs2_data_i, pc_plus4_i, jb_tgt_i, m_result_i;
  // Data memory port
  logic       dmem_ren_o, dmem_we_o;
  word_t      dmem_raddr_o, dmem_rdata_i, dmem_waddr_o, dmem_wdata_o;
  strb_t      dmem_wstrb_o;
  // Forwarding and WB outputs
  word_t      result_mem_o, ld_data_mem_o;
  logic       m_valid_o, reg_write_o, trap_o;
  trap_code_t trap_code_o;
  reg_idx_t   rd_o;
  res_src_t   res_src_o;
  word_t      result_wb_o, ld_data_wb_o;
  // Counts from the checker
  int         check_count, error_count;
  // Galois LFSR state
  logic [31:0] lfsr_state = 32'd98;
  // 16-word data memory
  word_t      mem [16];

  mem_stage #(
    .PIPELINED (1)
  ) dut (.*);

  mem_stage_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_valid_i      (s_valid_i),
    .stall_i        (stall_i),
    .reg_write_i    (reg_write_i),
    .mem_read_i     (mem_read_i),
    .mem_write_i    (mem_write_i),
    .trap_i         (trap_i),
    .res_src_i      (res_src_i),
    .trap_code_i    (trap_code_i),
    .rd_i           (rd_i),
    .funct3_i       (funct3_i),
    .alu_result_i   (alu_result_i),
    .rs2_data_i     (rs2_data_i),
    .pc_plus4_i     (pc_plus4_i),
    .jb_tgt_i       (jb_tgt_i),
    .m_result_i     (m_result_i),
    .dmem_ren_i     (dmem_ren_o),
    .dmem_we_i      (dmem_we_o),
    .dmem_raddr_i   (dmem_raddr_o),
    .dmem_waddr_i   (dmem_waddr_o),
    .dmem_wdata_i   (dmem_wdata_o),
    .dmem_wstrb_i   (dmem_wstrb_o),
    .result_mem_i   (result_mem_o),
    .ld_data_mem_i  (ld_data_mem_o),
    .wb_valid_i     (m_valid_o),
    .wb_reg_write_i (reg_write_o),
    .wb_trap_i      (trap_o),
    .wb_trap_code_i (trap_code_o),
    .wb_rd_i        (rd_o),
    .wb_res_src_i   (res_src_o),
    .result_wb_i    (result_wb_o),
    .ld_data_wb_i   (ld_data_wb_o),
    .check_count_o  (check_count),
    .error_count_o  (error_count)
  );

  always #4 clk = ~clk;

  // ======================================================================
  // Memory model
  // ======================================================================

  // Starting contents, every word differs
  function automatic word_t fill_word(input int idx);
    return word_t'(idx) * 32'h2545_F491 ^ 32'h8F1B_6C3D;
  endfunction

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] <= fill_word(i);
    end
  end

  // Read in the same cycle
  assign dmem_rdata_i = mem[dmem_raddr_o[5:2]];

  // Strobed write at the edge
  always @(posedge clk) begin
    if (dmem_we_o) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb_o[b]) begin
          mem[dmem_waddr_o[5:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
        end
      end
    end
  end

  // ======================================================================
  // Random source and stimulus
  // ======================================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Shift n LFSR bits into v, one step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    s_valid_i    = 1'b0;
    stall_i      = 1'b0;
    reg_write_i  = 1'b0;
    mem_read_i   = 1'b0;
    mem_write_i  = 1'b0;
    trap_i       = 1'b0;
    res_src_i    = RES_ALU;
    trap_code_i  = '0;
    rd_i         = '0;
    funct3_i     = F3_W;
    alu_result_i = '0;
    rs2_data_i   = '0;
    pc_plus4_i   = '0;
    jb_tgt_i     = '0;
    m_result_i   = '0;
  endtask

  // One random instruction on the EX side
  task automatic make_op();
    logic [31:0] kind;
    logic [31:0] sel;
    logic [31:0] addr;
    logic [31:0] r;
    take_bits(3, kind);
    take_bits(32, addr);
    take_bits(3, sel);
    // 0..2 store, 3..5 load, 6..7 no memory access
    mem_write_i = kind[2:0] <= 3'd2;
    mem_read_i  = kind[2:0] >= 3'd3 && kind[2:0] <= 3'd5;
    reg_write_i = !mem_write_i;
    if (mem_write_i) begin
      funct3_i  = (sel[1:0] == 2'd3) ? F3_W : {1'b0, sel[1:0]};
      res_src_i = RES_ALU;
    end else if (mem_read_i) begin
      case (sel[2:0])
        3'd0: funct3_i = F3_B;
        3'd1: funct3_i = F3_H;
        3'd3: funct3_i = F3_BU;
        3'd4: funct3_i = F3_HU;
        default: funct3_i = F3_W;
      endcase
      res_src_i = RES_MEM;
    end else begin
      funct3_i  = F3_W;
      res_src_i = (sel[2:0] > 3'd4) ? RES_ALU : sel[2:0];
    end
    // Mostly aligned, misaligned one time in four
    take_bits(2, r);
    if (r[1:0] != 2'd0 && funct3_i[1:0] != 2'd0) begin
      addr[0] = 1'b0;
      if (funct3_i[1:0] == 2'd2) begin
        addr[1] = 1'b0;
      end
    end
    alu_result_i = addr;
    // Rare incoming trap with a random cause
    take_bits(4, r);
    trap_i = (r[3:0] == 4'd0);
    take_bits(2, r);
    trap_code_i = r[1:0];
    take_bits(5, r);
    rd_i = r[4:0];
    take_bits(32, rs2_data_i);
    take_bits(32, pc_plus4_i);
    take_bits(32, jb_tgt_i);
    take_bits(32, m_result_i);
  endtask

  initial begin
    logic [31:0] r;
    int          stall_cycles;
    clear_inputs();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      make_op();
      // Bubble one time in eight
      take_bits(3, r);
      s_valid_i = (r[2:0] != 3'd0);
      // Hold for zero, one or two extra cycles
      take_bits(2, r);
      stall_cycles = (r[1:0] == 2'd3) ? 2 : ((r[1:0] == 2'd2) ? 1 : 0);
      stall_i = (stall_cycles != 0);
      repeat (stall_cycles) next_cycle();
      stall_i = 1'b0;
      next_cycle();
    end
    s_valid_i = 1'b0;
    repeat (2) next_cycle();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, four cycles per operation plus margin
  initial begin
    #((N_OPS * 4 + 20) * 8);
    $display("Timeout: the test sequence did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- mem_stage.f
design/mem_stage_pkg.sv
design/store_formatter.sv
design/load_formatter.sv
design/mem_access_unit.sv
design/mem_wb_reg.sv
design/mem_stage.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

//--- sim.sh
#!/bin/sh
# Build and run the MEM stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mem_stage.f --top-module tb_mem_stage -o tb_mem_stage_sim

output=$(./obj_dir/tb_mem_stage_sim)
echo "$output"

if echo "$output" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1
